//--- Makefile
TOP = tb_nanorv32_decode

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module $(TOP)

# A simulator error exit is logged as a failure too
run: compile
	./obj_dir/V$(TOP) > run.log 2>&1 || echo "Test FAILED" >> run.log
	@cat run.log
	@if grep -q "Test FAILED" run.log; then \
		echo "Simulation failed, see run.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir run.log

//--- sources.f
+incdir+src
src/nanorv32_pkg.sv
src/nanorv32_instr_match.sv
src/nanorv32_ctrl_table.sv
src/nanorv32_decode_stage.sv
tests/nanorv32_decode_asserts.sv
tests/tb_nanorv32_decode.sv

//--- src/nanorv32_ctrl_table.sv
`timescale 1ns/1ps

module nanorv32_ctrl_table (
    input  nanorv32_pkg::instr_kind_e  instr_kind,
    output nanorv32_pkg::decode_ctrl_t ctrl
);

    always_comb begin
        // Safe default, also used for illegal words, fences and system calls
        ctrl.pc_next_sel            = nanorv32_pkg::PC_NEXT_PLUS4;
        ctrl.alu_op_sel             = nanorv32_pkg::ALU_OP_NOP;
        ctrl.alu_porta_sel          = nanorv32_pkg::PORTA_RS1;
        ctrl.alu_portb_sel          = nanorv32_pkg::PORTB_RS2;
        ctrl.datamem_size_read_sel  = nanorv32_pkg::SIZE_READ_WORD;
        ctrl.datamem_size_write_sel = nanorv32_pkg::SIZE_WRITE_WORD;
        ctrl.datamem_read_sel       = 1'b0;
        ctrl.datamem_write_sel      = 1'b0;
        ctrl.regfile_source_sel     = nanorv32_pkg::REGFILE_SRC_ALU;
        ctrl.regfile_write_sel      = 1'b0;

        // ALU operation
        case (instr_kind)
            nanorv32_pkg::INSTR_ADD, nanorv32_pkg::INSTR_ADDI,
            nanorv32_pkg::INSTR_LB, nanorv32_pkg::INSTR_LH, nanorv32_pkg::INSTR_LW,
            nanorv32_pkg::INSTR_LBU, nanorv32_pkg::INSTR_LHU,
            nanorv32_pkg::INSTR_SB, nanorv32_pkg::INSTR_SH, nanorv32_pkg::INSTR_SW,
            nanorv32_pkg::INSTR_JAL, nanorv32_pkg::INSTR_JALR, nanorv32_pkg::INSTR_AUIPC:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_ADD;
            nanorv32_pkg::INSTR_SUB:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_SUB;
            nanorv32_pkg::INSTR_AND, nanorv32_pkg::INSTR_ANDI:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_AND;
            nanorv32_pkg::INSTR_OR, nanorv32_pkg::INSTR_ORI:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_OR;
            nanorv32_pkg::INSTR_XOR, nanorv32_pkg::INSTR_XORI:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_XOR;
            nanorv32_pkg::INSTR_SLL, nanorv32_pkg::INSTR_SLLI:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_LSHIFT;
            nanorv32_pkg::INSTR_SRL, nanorv32_pkg::INSTR_SRLI:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_RSHIFT;
            nanorv32_pkg::INSTR_SRA, nanorv32_pkg::INSTR_SRAI:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_ARSHIFT;
            nanorv32_pkg::INSTR_BEQ:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_EQ;
            nanorv32_pkg::INSTR_BNE:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_NEQ;
            nanorv32_pkg::INSTR_SLT, nanorv32_pkg::INSTR_SLTI, nanorv32_pkg::INSTR_BLT:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_LT_SIGNED;
            nanorv32_pkg::INSTR_SLTU, nanorv32_pkg::INSTR_SLTIU, nanorv32_pkg::INSTR_BLTU:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_LT_UNSIGNED;
            nanorv32_pkg::INSTR_BGE:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_GE_SIGNED;
            nanorv32_pkg::INSTR_BGEU:
                ctrl.alu_op_sel = nanorv32_pkg::ALU_OP_GE_UNSIGNED;
            default: ;
        endcase

        // Operands, next PC and writeback by instruction format
        case (instr_kind)
            nanorv32_pkg::INSTR_ADD, nanorv32_pkg::INSTR_SUB, nanorv32_pkg::INSTR_SLL,
            nanorv32_pkg::INSTR_SLT, nanorv32_pkg::INSTR_SLTU, nanorv32_pkg::INSTR_XOR,
            nanorv32_pkg::INSTR_SRL, nanorv32_pkg::INSTR_SRA, nanorv32_pkg::INSTR_OR,
            nanorv32_pkg::INSTR_AND: begin
                ctrl.regfile_write_sel = 1'b1;
            end
            nanorv32_pkg::INSTR_ADDI, nanorv32_pkg::INSTR_SLTI, nanorv32_pkg::INSTR_SLTIU,
            nanorv32_pkg::INSTR_XORI, nanorv32_pkg::INSTR_ORI, nanorv32_pkg::INSTR_ANDI: begin
                ctrl.alu_portb_sel     = nanorv32_pkg::PORTB_IMM12;
                ctrl.regfile_write_sel = 1'b1;
            end
            nanorv32_pkg::INSTR_SLLI, nanorv32_pkg::INSTR_SRLI, nanorv32_pkg::INSTR_SRAI: begin
                ctrl.alu_portb_sel     = nanorv32_pkg::PORTB_SHAMT;
                ctrl.regfile_write_sel = 1'b1;
            end
            nanorv32_pkg::INSTR_LB, nanorv32_pkg::INSTR_LH, nanorv32_pkg::INSTR_LW,
            nanorv32_pkg::INSTR_LBU, nanorv32_pkg::INSTR_LHU: begin
                ctrl.alu_portb_sel      = nanorv32_pkg::PORTB_IMM12;
                ctrl.datamem_read_sel   = 1'b1;
                ctrl.regfile_source_sel = nanorv32_pkg::REGFILE_SRC_DATAMEM;
                ctrl.regfile_write_sel  = 1'b1;
            end
            nanorv32_pkg::INSTR_SB, nanorv32_pkg::INSTR_SH, nanorv32_pkg::INSTR_SW: begin
                ctrl.alu_portb_sel     = nanorv32_pkg::PORTB_IMM12HILO;
                ctrl.datamem_write_sel = 1'b1;
            end
            nanorv32_pkg::INSTR_BEQ, nanorv32_pkg::INSTR_BNE, nanorv32_pkg::INSTR_BLT,
            nanorv32_pkg::INSTR_BGE, nanorv32_pkg::INSTR_BLTU, nanorv32_pkg::INSTR_BGEU: begin
                ctrl.pc_next_sel = nanorv32_pkg::PC_NEXT_COND_PC_PLUS_IMMSB;
            end
            nanorv32_pkg::INSTR_JAL: begin
                ctrl.pc_next_sel        = nanorv32_pkg::PC_NEXT_ALU_RES;
                ctrl.alu_porta_sel      = nanorv32_pkg::PORTA_PC_EXE;
                ctrl.alu_portb_sel      = nanorv32_pkg::PORTB_IMM20UJ;
                ctrl.regfile_source_sel = nanorv32_pkg::REGFILE_SRC_PC_EXE_PLUS_4;
                ctrl.regfile_write_sel  = 1'b1;
            end
            nanorv32_pkg::INSTR_JALR: begin
                ctrl.pc_next_sel        = nanorv32_pkg::PC_NEXT_ALU_RES;
                ctrl.alu_portb_sel      = nanorv32_pkg::PORTB_IMM12;
                ctrl.regfile_source_sel = nanorv32_pkg::REGFILE_SRC_PC_EXE_PLUS_4;
                ctrl.regfile_write_sel  = 1'b1;
            end
            nanorv32_pkg::INSTR_AUIPC: begin
                ctrl.alu_porta_sel     = nanorv32_pkg::PORTA_PC_EXE;
                ctrl.alu_portb_sel     = nanorv32_pkg::PORTB_IMM20U;
                ctrl.regfile_write_sel = 1'b1;
            end
            // ALU passes port B through unchanged
            nanorv32_pkg::INSTR_LUI: begin
                ctrl.alu_portb_sel     = nanorv32_pkg::PORTB_IMM20U;
                ctrl.regfile_write_sel = 1'b1;
            end
            default: ;
        endcase

        // Access size of narrow loads and stores
        case (instr_kind)
            nanorv32_pkg::INSTR_LB:
                ctrl.datamem_size_read_sel = nanorv32_pkg::SIZE_READ_BYTE;
            nanorv32_pkg::INSTR_LBU:
                ctrl.datamem_size_read_sel = nanorv32_pkg::SIZE_READ_BYTE_UNSIGNED;
            nanorv32_pkg::INSTR_LH:
                ctrl.datamem_size_read_sel = nanorv32_pkg::SIZE_READ_HALFWORD;
            nanorv32_pkg::INSTR_LHU:
                ctrl.datamem_size_read_sel = nanorv32_pkg::SIZE_READ_HALFWORD_UNSIGNED;
            nanorv32_pkg::INSTR_SB:
                ctrl.datamem_size_write_sel = nanorv32_pkg::SIZE_WRITE_BYTE;
            nanorv32_pkg::INSTR_SH:
                ctrl.datamem_size_write_sel = nanorv32_pkg::SIZE_WRITE_HALFWORD;
            default: ;
        endcase
    end

endmodule

//--- src/nanorv32_decode_stage.sv
`timescale 1ns/1ps
`include "nanorv32_defs.svh"

module nanorv32_decode_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  nanorv32_pkg::instr_t       instr,
    output logic                       dec_valid,
    output nanorv32_pkg::decode_ctrl_t ctrl,
    output logic                       illegal_instruction
);

    nanorv32_pkg::instr_t      instruction_r;
    nanorv32_pkg::instr_kind_e instr_kind;

    // Instruction register, holds its word between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instruction_r <= `NANORV32_RESET_INSTR;
        end else if (instr_valid) begin
            instruction_r <= instr;
        end
    end

    // Decode is valid the cycle after each accepted strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    nanorv32_instr_match u_instr_match (
        .instruction_r       (instruction_r),
        .instr_kind          (instr_kind),
        .illegal_instruction (illegal_instruction)
    );

    nanorv32_ctrl_table u_ctrl_table (
        .instr_kind (instr_kind),
        .ctrl       (ctrl)
    );

endmodule

//--- src/nanorv32_defs.svh
`ifndef NANORV32_DEFS_SVH
`define NANORV32_DEFS_SVH

// Datapath word width
`define NANORV32_XLEN 32

// RV32I major opcodes, low two bits always 11
`define NANORV32_OPC_LUI      7'b0110111
`define NANORV32_OPC_AUIPC    7'b0010111
`define NANORV32_OPC_JAL      7'b1101111
`define NANORV32_OPC_JALR     7'b1100111
`define NANORV32_OPC_BRANCH   7'b1100011
`define NANORV32_OPC_LOAD     7'b0000011
`define NANORV32_OPC_STORE    7'b0100011
`define NANORV32_OPC_OP_IMM   7'b0010011
`define NANORV32_OPC_OP       7'b0110011
`define NANORV32_OPC_MISC_MEM 7'b0001111
`define NANORV32_OPC_SYSTEM   7'b1110011

// ADDI x0,x0,0
`define NANORV32_RESET_INSTR  32'h0000_0013

`endif

//--- src/nanorv32_instr_match.sv
`timescale 1ns/1ps
`include "nanorv32_defs.svh"

module nanorv32_instr_match (
    input  nanorv32_pkg::instr_t      instruction_r,
    output nanorv32_pkg::instr_kind_e instr_kind,
    output logic                      illegal_instruction
);

    nanorv32_pkg::opcode_t opcode;
    nanorv32_pkg::funct3_t funct3;
    nanorv32_pkg::funct7_t funct7;
    logic                  funct7_zero;
    logic                  funct7_alt;

    assign opcode = instruction_r[6:0];
    assign funct3 = instruction_r[14:12];
    assign funct7 = instruction_r[31:25];

    // SUB, SRA and SRAI use the alternate funct7
    assign funct7_zero = (funct7 == 7'b0000000);
    assign funct7_alt  = (funct7 == 7'b0100000);

    // Opcode values carry the 11 low bits, so a compressed word never matches
    always_comb begin
        instr_kind = nanorv32_pkg::INSTR_ILLEGAL;
        case (opcode)
            `NANORV32_OPC_LUI:   instr_kind = nanorv32_pkg::INSTR_LUI;
            `NANORV32_OPC_AUIPC: instr_kind = nanorv32_pkg::INSTR_AUIPC;
            `NANORV32_OPC_JAL:   instr_kind = nanorv32_pkg::INSTR_JAL;
            `NANORV32_OPC_JALR: begin
                if (funct3 == 3'b000)
                    instr_kind = nanorv32_pkg::INSTR_JALR;
            end
            `NANORV32_OPC_BRANCH: begin
                case (funct3)
                    3'b000:  instr_kind = nanorv32_pkg::INSTR_BEQ;
                    3'b001:  instr_kind = nanorv32_pkg::INSTR_BNE;
                    3'b100:  instr_kind = nanorv32_pkg::INSTR_BLT;
                    3'b101:  instr_kind = nanorv32_pkg::INSTR_BGE;
                    3'b110:  instr_kind = nanorv32_pkg::INSTR_BLTU;
                    3'b111:  instr_kind = nanorv32_pkg::INSTR_BGEU;
                    default: instr_kind = nanorv32_pkg::INSTR_ILLEGAL;
                endcase
            end
            `NANORV32_OPC_LOAD: begin
                case (funct3)
                    3'b000:  instr_kind = nanorv32_pkg::INSTR_LB;
                    3'b001:  instr_kind = nanorv32_pkg::INSTR_LH;
                    3'b010:  instr_kind = nanorv32_pkg::INSTR_LW;
                    3'b100:  instr_kind = nanorv32_pkg::INSTR_LBU;
                    3'b101:  instr_kind = nanorv32_pkg::INSTR_LHU;
                    default: instr_kind = nanorv32_pkg::INSTR_ILLEGAL;
                endcase
            end
            `NANORV32_OPC_STORE: begin
                case (funct3)
                    3'b000:  instr_kind = nanorv32_pkg::INSTR_SB;
                    3'b001:  instr_kind = nanorv32_pkg::INSTR_SH;
                    3'b010:  instr_kind = nanorv32_pkg::INSTR_SW;
                    default: instr_kind = nanorv32_pkg::INSTR_ILLEGAL;
                endcase
            end
            `NANORV32_OPC_OP_IMM: begin
                case (funct3)
                    3'b000: instr_kind = nanorv32_pkg::INSTR_ADDI;
                    3'b010: instr_kind = nanorv32_pkg::INSTR_SLTI;
                    3'b011: instr_kind = nanorv32_pkg::INSTR_SLTIU;
                    3'b100: instr_kind = nanorv32_pkg::INSTR_XORI;
                    3'b110: instr_kind = nanorv32_pkg::INSTR_ORI;
                    3'b111: instr_kind = nanorv32_pkg::INSTR_ANDI;
                    3'b001: begin
                        if (funct7_zero)
                            instr_kind = nanorv32_pkg::INSTR_SLLI;
                    end
                    default: begin
                        if (funct7_zero)
                            instr_kind = nanorv32_pkg::INSTR_SRLI;
                        else if (funct7_alt)
                            instr_kind = nanorv32_pkg::INSTR_SRAI;
                    end
                endcase
            end
            `NANORV32_OPC_OP: begin
                if (funct7_zero) begin
                    case (funct3)
                        3'b000:  instr_kind = nanorv32_pkg::INSTR_ADD;
                        3'b001:  instr_kind = nanorv32_pkg::INSTR_SLL;
                        3'b010:  instr_kind = nanorv32_pkg::INSTR_SLT;
                        3'b011:  instr_kind = nanorv32_pkg::INSTR_SLTU;
                        3'b100:  instr_kind = nanorv32_pkg::INSTR_XOR;
                        3'b101:  instr_kind = nanorv32_pkg::INSTR_SRL;
                        3'b110:  instr_kind = nanorv32_pkg::INSTR_OR;
                        default: instr_kind = nanorv32_pkg::INSTR_AND;
                    endcase
                end else if (funct7_alt) begin
                    if (funct3 == 3'b000)
                        instr_kind = nanorv32_pkg::INSTR_SUB;
                    else if (funct3 == 3'b101)
                        instr_kind = nanorv32_pkg::INSTR_SRA;
                end
            end
            `NANORV32_OPC_MISC_MEM: begin
                if (funct3 == 3'b000)
                    instr_kind = nanorv32_pkg::INSTR_FENCE;
                else if (funct3 == 3'b001)
                    instr_kind = nanorv32_pkg::INSTR_FENCE_I;
            end
            `NANORV32_OPC_SYSTEM: begin
                // Only the two exact environment call words
                if (instruction_r == 32'h0000_0073)
                    instr_kind = nanorv32_pkg::INSTR_SCALL;
                else if (instruction_r == 32'h0010_0073)
                    instr_kind = nanorv32_pkg::INSTR_SBREAK;
            end
            default: instr_kind = nanorv32_pkg::INSTR_ILLEGAL;
        endcase
    end

    assign illegal_instruction = (instr_kind == nanorv32_pkg::INSTR_ILLEGAL);

endmodule

//--- src/nanorv32_pkg.sv
`include "nanorv32_defs.svh"

package nanorv32_pkg;

    // Instruction word and its fields
    typedef logic [`NANORV32_XLEN-1:0] instr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Instructions recognised by the decoder
    // OR sits after BEQ so that the other codes keep their order
    typedef enum logic [5:0] {
        INSTR_AND,
        INSTR_LBU,
        INSTR_FENCE,
        INSTR_SW,
        INSTR_BLTU,
        INSTR_XOR,
        INSTR_SLTU,
        INSTR_ANDI,
        INSTR_JALR,
        INSTR_BLT,
        INSTR_SCALL,
        INSTR_FENCE_I,
        INSTR_JAL,
        INSTR_LH,
        INSTR_LW,
        INSTR_ADD,
        INSTR_AUIPC,
        INSTR_LUI,
        INSTR_BNE,
        INSTR_SBREAK,
        INSTR_BGEU,
        INSTR_SLTIU,
        INSTR_SRAI,
        INSTR_ORI,
        INSTR_XORI,
        INSTR_LB,
        INSTR_SUB,
        INSTR_SRA,
        INSTR_BGE,
        INSTR_SLT,
        INSTR_SRLI,
        INSTR_SLTI,
        INSTR_SRL,
        INSTR_SLL,
        INSTR_LHU,
        INSTR_SH,
        INSTR_SLLI,
        INSTR_ADDI,
        INSTR_SB,
        INSTR_BEQ,
        INSTR_OR,
        INSTR_ILLEGAL
    } instr_kind_e;

    typedef enum logic [1:0] {
        PC_NEXT_PLUS4,
        PC_NEXT_ALU_RES,
        PC_NEXT_COND_PC_PLUS_IMMSB
    } pc_next_sel_e;

    typedef enum logic [3:0] {
        ALU_OP_NOP,
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_XOR,
        ALU_OP_LSHIFT,
        ALU_OP_RSHIFT,
        ALU_OP_ARSHIFT,
        ALU_OP_EQ,
        ALU_OP_NEQ,
        ALU_OP_LT_SIGNED,
        ALU_OP_LT_UNSIGNED,
        ALU_OP_GE_SIGNED,
        ALU_OP_GE_UNSIGNED
    } alu_op_sel_e;

    typedef enum logic {
        PORTA_RS1,
        PORTA_PC_EXE
    } alu_porta_sel_e;

    typedef enum logic [2:0] {
        PORTB_RS2,
        PORTB_IMM12,
        PORTB_IMM12HILO,
        PORTB_IMM20U,
        PORTB_IMM20UJ,
        PORTB_SHAMT
    } alu_portb_sel_e;

    typedef enum logic [2:0] {
        SIZE_READ_WORD,
        SIZE_READ_BYTE,
        SIZE_READ_BYTE_UNSIGNED,
        SIZE_READ_HALFWORD,
        SIZE_READ_HALFWORD_UNSIGNED
    } mem_size_read_e;

    typedef enum logic [1:0] {
        SIZE_WRITE_WORD,
        SIZE_WRITE_BYTE,
        SIZE_WRITE_HALFWORD
    } mem_size_write_e;

    typedef enum logic [1:0] {
        REGFILE_SRC_ALU,
        REGFILE_SRC_DATAMEM,
        REGFILE_SRC_PC_EXE_PLUS_4
    } regfile_source_sel_e;

    // Datapath selects, 20 bits
    typedef struct packed {
        pc_next_sel_e        pc_next_sel;
        alu_op_sel_e         alu_op_sel;
        alu_porta_sel_e      alu_porta_sel;
        alu_portb_sel_e      alu_portb_sel;
        mem_size_read_e      datamem_size_read_sel;
        mem_size_write_e     datamem_size_write_sel;
        logic                datamem_read_sel;
        logic                datamem_write_sel;
        regfile_source_sel_e regfile_source_sel;
        logic                regfile_write_sel;
    } decode_ctrl_t;

endpackage

//--- tests/decode_stim.txt
// instr strobe illegal ctrl, one vector per cycle
// ctrl is the 20-bit control word as five hex digits
deadbeef 0 0 04401 // no strobe after reset, ADDI from the reset word
007302b3 1 0 04001 // add
407302b3 1 0 08001 // sub
007312b3 1 0 18001 // sll
007322b3 1 0 2c001 // slt
007332b3 1 0 30001 // sltu
007342b3 1 0 14001 // xor
007352b3 1 0 1c001 // srl
407352b3 1 0 20001 // sra
007362b3 1 0 10001 // or
007372b3 1 0 0c001 // and
12358513 1 0 04401 // addi
1235a513 1 0 2c401 // slti
1235b513 1 0 30401 // sltiu
1235c513 1 0 14401 // xori
1235e513 1 0 10401 // ori
1235f513 1 0 0c401 // andi
00359513 1 0 19401 // slli
0035d513 1 0 1d401 // srli
4035d513 1 0 21401 // srai
01010603 1 0 04493 // lb
01011603 1 0 04593 // lh
01014603 1 0 04513 // lbu
01015603 1 0 04613 // lhu
00d10423 1 0 04828 // sb
00d11423 1 0 04848 // sh
00e79463 1 0 a8000 // bne
00e7c463 1 0 ac000 // blt
00e7d463 1 0 b4000 // bge
00e7e463 1 0 b0000 // bltu
00e7f463 1 0 b8000 // bgeu
000280e7 1 0 44405 // jalr
12345197 1 0 06c01 // auipc
0ff0000f 1 0 00000 // fence
0000100f 1 0 00000 // fence.i
00000073 1 0 00000 // scall
00100073 1 0 00000 // sbreak
01012603 1 0 04413 // lw, back-to-back run of load, store, branch, jal
00d12423 1 0 04808 // sw
00e78463 1 0 a4000 // beq
010000ef 1 0 47005 // jal
abcde237 1 0 00c01 // lui
13579bdf 0 0 00c01 // no strobe, lui decode held
007302b3 0 0 00c01 // no strobe, instr changes
1234507b 1 1 00000 // unknown opcode
12358511 1 1 00000 // low bits 01
027302b3 1 1 00000 // add with funct7 0000001
00e7a463 1 1 00000 // branch with funct3 010
00008073 1 1 00000 // scall with rs1 x1
00000013 0 1 00000 // no strobe, illegal decode held
12358513 1 0 04401 // addi after an idle cycle

//--- tests/nanorv32_decode_asserts.sv
`timescale 1ns/1ps

module nanorv32_decode_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       instr_valid,
    input logic                       dec_valid,
    input nanorv32_pkg::decode_ctrl_t ctrl,
    input logic                       illegal_instruction
);

    // No decode is reported while the stage is held in reset
    dec_valid_in_reset: assert property (@(posedge clk) !rst_n |-> !dec_valid)
        else $error("dec_valid high while rst_n is low");

    // One cycle from strobe to decode
    dec_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n) dec_valid == $past(instr_valid))
        else $error("dec_valid does not follow instr_valid by one cycle");

    // An illegal word must not change architectural state
    illegal_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        illegal_instruction |-> (!ctrl.regfile_write_sel && !ctrl.datamem_write_sel))
        else $error("illegal instruction enables a register or memory write");

endmodule

//--- tests/tb_nanorv32_decode.sv
`timescale 1ns/1ps

module tb_nanorv32_decode;

    localparam int STIM_WORDS    = 256;
    localparam int RESET_TIMEOUT = 50;

    logic                       clk;
    logic                       rst_n;
    logic                       instr_valid;
    nanorv32_pkg::instr_t       instr;
    logic                       dec_valid;
    nanorv32_pkg::decode_ctrl_t ctrl;
    logic                       illegal_instruction;

    // Four words per vector holding instruction, strobe, illegal flag and control word
    logic [31:0] stim [0:STIM_WORDS-1];

    int value_errors;
    int other_errors;

    nanorv32_decode_stage dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .instr_valid         (instr_valid),
        .instr               (instr),
        .dec_valid           (dec_valid),
        .ctrl                (ctrl),
        .illegal_instruction (illegal_instruction)
    );

    bind nanorv32_decode_stage nanorv32_decode_asserts u_asserts (
        .clk                 (clk),
        .rst_n               (rst_n),
        .instr_valid         (instr_valid),
        .dec_valid           (dec_valid),
        .ctrl                (ctrl),
        .illegal_instruction (illegal_instruction)
    );

    always #10 clk = ~clk;

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_ctrl(input string name, input nanorv32_pkg::decode_ctrl_t exp,
                              input nanorv32_pkg::decode_ctrl_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %05h, got %05h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_vector(input int k);
        check_bit("dec_valid", stim[4*k+1][0], dec_valid);
        check_bit("illegal_instruction", stim[4*k+2][0], illegal_instruction);
        check_ctrl("ctrl", nanorv32_pkg::decode_ctrl_t'(stim[4*k+3][19:0]), ctrl);
    endtask

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    initial begin
        int n_vec;
        int cycles;
        int i;
        clk          = 1'b0;
        instr        = '0;
        instr_valid  = 1'b0;
        value_errors = 0;
        other_errors = 0;

        // All ones marks the end of the vectors in the file
        for (i = 0; i < STIM_WORDS; i++)
            stim[i] = '1;
        $readmemh("tests/decode_stim.txt", stim);
        n_vec = 0;
        while (n_vec < STIM_WORDS / 4 && stim[4*n_vec+1] != 32'hffff_ffff)
            n_vec++;
        if (n_vec == 0) begin
            $display("No vectors were read from tests/decode_stim.txt");
            other_errors++;
        end

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Test FAILED");
            $finish;
        end else begin
            // Drive each vector after an edge and check it after the following one
            for (i = 0; i <= n_vec; i++) begin
                @(posedge clk);
                #1;
                if (i > 0)
                    compare_vector(i - 1);
                if (i < n_vec) begin
                    instr       = stim[4*i];
                    instr_valid = stim[4*i+1][0];
                end else begin
                    instr_valid = 1'b0;
                end
            end

            $display("Vectors: %0d, value errors: %0d, other errors: %0d",
                     n_vec, value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule
